// File: hw/codec_cfg_consts.svh
`ifndef CODEC_CFG_CONSTS_SVH
`define CODEC_CFG_CONSTS_SVH

// Codec on the I2C bus, first wire byte is 34 hex
`define CODEC_I2C_ADDR      7'h1A

// Control word table
`define CFG_TABLE_DEPTH     8
`define CFG_DEFAULT_COUNT   7

// System clocks per quarter SCL period
`define I2C_QUARTER_DIV     4

// APB register map, 8-bit address
`define CFG_REG_CTRL        8'h00
`define CFG_REG_STATUS      8'h04
`define CFG_REG_COUNT       8'h08
`define CFG_REG_TABLE       8'h40   // Entry i at base + 4*i

`endif

// File: hw/codec_cfg_pkg.sv
`default_nettype none

package codec_cfg_pkg;

    // One codec control word: register address then 9 data bits
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } codec_word_t;

    // Single three-byte write for the I2C engine
    typedef struct packed {
        logic [6:0]  dev_addr;
        codec_word_t word;
    } i2c_cmd_t;

    typedef struct packed {
        logic [1:0] spare;   // Reads zero
        logic [2:0] index;   // Entry in flight or entry that failed
        logic       nack;
        logic       done;
        logic       busy;
    } cfg_status_t;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: hw/codec_init_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "codec_cfg_consts.svh"

module codec_init_table import codec_cfg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_wr_en,
    input  logic [2:0]  i_wr_idx,
    input  codec_word_t i_wr_word,
    input  logic [2:0]  i_host_idx,
    input  logic [2:0]  i_seq_idx,
    output codec_word_t o_host_word,
    output codec_word_t o_seq_word
);

    localparam int unsigned DEPTH = `CFG_TABLE_DEPTH;

    // Power-up order for a WM8731-style codec
    localparam codec_word_t POWER_UP [DEPTH] = '{
        '{reg_addr: 7'h0F, reg_data: 9'h000},   // Reset
        '{reg_addr: 7'h04, reg_data: 9'h015},   // Analogue path
        '{reg_addr: 7'h05, reg_data: 9'h000},   // Digital path
        '{reg_addr: 7'h06, reg_data: 9'h000},   // Power down, all on
        '{reg_addr: 7'h07, reg_data: 9'h042},   // I2S, master mode
        '{reg_addr: 7'h08, reg_data: 9'h019},   // Sampling
        '{reg_addr: 7'h09, reg_data: 9'h001},   // Active
        '{reg_addr: 7'h00, reg_data: 9'h000}    // Unused slot
    };

    codec_word_t words [DEPTH];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= POWER_UP[i];
            end
        end else if (i_wr_en) begin
            words[i_wr_idx] <= i_wr_word;
        end
    end

    // Both read ports registered, one cycle latency
    always_ff @(posedge i_clk) begin
        o_host_word <= words[i_host_idx];
        o_seq_word  <= words[i_seq_idx];
    end

    // A write must name a real entry and carry a defined word
    a_wr_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_en |-> !$isunknown({i_wr_idx, i_wr_word}));

endmodule

`default_nettype wire

// File: hw/i2c_write_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_write_master import codec_cfg_pkg::*; #(
    parameter int unsigned QUARTER_DIV = 4
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_cmd_valid,
    input  i2c_cmd_t i_cmd,
    input  logic     i_sda,
    output logic     o_cmd_ready,
    output logic     o_result_valid,
    output logic     o_result_nack,
    output logic     o_scl_oe,
    output logic     o_sda_oe
);

    localparam int unsigned QW         = (QUARTER_DIV > 1) ? $clog2(QUARTER_DIV) : 1;
    localparam int unsigned FRAME_BITS = 27;   // 3 bytes plus 3 ack slots

    typedef enum logic [2:0] {
        S_IDLE, S_START, S_BIT_LO, S_BIT_HI, S_ACK, S_STOP
    } phase_t;

    phase_t                phase;
    logic [QW-1:0]         qdiv;
    logic [1:0]            qtr;         // Quarter within the current slot
    logic [4:0]            slot;
    logic [FRAME_BITS-1:0] frame;
    logic                  nack_seen;
    logic                  tick;
    logic                  next_is_ack;

    function automatic logic is_ack_slot(input logic [4:0] s);
        return (s == 5'd8) || (s == 5'd17) || (s == 5'd26);
    endfunction

    assign tick        = (qdiv == QW'(QUARTER_DIV - 1));
    assign next_is_ack = is_ack_slot(slot + 5'd1);
    assign o_cmd_ready = (phase == S_IDLE);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            qdiv <= '0;
        end else if (phase == S_IDLE || tick) begin
            qdiv <= '0;
        end else begin
            qdiv <= qdiv + 1'b1;
        end
    end

    // Ack slots are ones in the frame, so SDA is released there
    always_ff @(posedge i_clk) begin
        if (o_cmd_ready && i_cmd_valid) begin
            frame <= {i_cmd.dev_addr, 1'b0, 1'b1, i_cmd.word[15:8], 1'b1,
                      i_cmd.word[7:0], 1'b1};
        end else if (tick && qtr == 2'd3 && (phase == S_BIT_HI || phase == S_ACK)) begin
            frame <= {frame[FRAME_BITS-2:0], 1'b1};
        end
    end

    // Each tick closes a quarter and sets the lines for the next one
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase          <= S_IDLE;
            qtr            <= 2'd0;
            slot           <= 5'd0;
            nack_seen      <= 1'b0;
            o_scl_oe       <= 1'b0;
            o_sda_oe       <= 1'b0;
            o_result_valid <= 1'b0;
            o_result_nack  <= 1'b0;
        end else begin
            o_result_valid <= 1'b0;
            if (phase == S_IDLE) begin
                qtr <= 2'd0;
                if (i_cmd_valid) begin
                    slot      <= 5'd0;
                    nack_seen <= 1'b0;
                    phase     <= S_START;
                end
            end else if (tick) begin
                qtr <= qtr + 2'd1;
                case (phase)
                    S_START: begin
                        if (qtr == 2'd0) o_sda_oe <= 1'b1;   // SDA falls, SCL high
                        if (qtr == 2'd2) o_scl_oe <= 1'b1;
                        if (qtr == 2'd3) phase <= S_BIT_LO;
                    end
                    S_BIT_LO: begin
                        if (qtr == 2'd0) o_sda_oe <= ~frame[FRAME_BITS-1];
                        if (qtr == 2'd1) begin
                            o_scl_oe <= 1'b0;
                            phase    <= S_BIT_HI;
                        end
                    end
                    S_BIT_HI: begin
                        if (qtr == 2'd3) begin
                            o_scl_oe <= 1'b1;
                            slot     <= slot + 5'd1;
                            phase    <= next_is_ack ? S_ACK : S_BIT_LO;
                        end
                    end
                    S_ACK: begin
                        if (qtr == 2'd0) o_sda_oe <= ~frame[FRAME_BITS-1];
                        if (qtr == 2'd1) o_scl_oe <= 1'b0;
                        if (qtr == 2'd2 && i_sda) nack_seen <= 1'b1;   // Middle of high phase
                        if (qtr == 2'd3) begin
                            o_scl_oe <= 1'b1;
                            slot     <= slot + 5'd1;
                            // Refused byte skips the rest of the frame
                            phase    <= (nack_seen || slot == 5'(FRAME_BITS - 1)) ?
                                        S_STOP : S_BIT_LO;
                        end
                    end
                    S_STOP: begin
                        if (qtr == 2'd0) o_sda_oe <= 1'b1;
                        if (qtr == 2'd1) o_scl_oe <= 1'b0;
                        if (qtr == 2'd2) o_sda_oe <= 1'b0;   // SDA rises, SCL high
                        if (qtr == 2'd3) begin
                            phase          <= S_IDLE;
                            o_result_valid <= 1'b1;
                            o_result_nack  <= nack_seen;
                        end
                    end
                    default: phase <= S_IDLE;
                endcase
            end
        end
    end

    // With SCL high, SDA may only move for start and stop
    a_sda_stable_scl_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($changed(o_sda_oe) && !o_scl_oe) |-> (phase == S_START || phase == S_STOP));

    // A command not yet taken stays offered and unchanged
    a_cmd_held_until_taken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cmd_valid && !o_cmd_ready) |=> (i_cmd_valid && $stable(i_cmd)));

endmodule

`default_nettype wire

// File: hw/codec_init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "codec_cfg_consts.svh"

module codec_init_sequencer import codec_cfg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic [3:0]  i_count,
    input  codec_word_t i_word,
    input  logic        i_cmd_ready,
    input  logic        i_result_valid,
    input  logic        i_result_nack,
    output logic [2:0]  o_rd_idx,
    output logic        o_cmd_valid,
    output i2c_cmd_t    o_cmd,
    output cfg_status_t o_status
);

    typedef enum logic [2:0] {S_IDLE, S_READ, S_ISSUE, S_WAIT, S_NEXT} seq_state_t;

    seq_state_t state;
    logic [2:0] idx;
    logic       done_q;
    logic       nack_q;

    assign o_rd_idx = idx;
    assign o_status = '{spare: 2'b00, index: idx, nack: nack_q, done: done_q,
                        busy: (state != S_IDLE)};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state       <= S_IDLE;
            idx         <= 3'd0;
            done_q      <= 1'b0;
            nack_q      <= 1'b0;
            o_cmd_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        idx    <= 3'd0;
                        done_q <= 1'b0;
                        nack_q <= 1'b0;
                        state  <= S_READ;
                    end
                end
                S_READ:  state <= S_ISSUE;   // Table port registers the entry
                S_ISSUE: begin
                    o_cmd_valid <= 1'b1;
                    state       <= S_WAIT;
                end
                S_WAIT: begin
                    if (o_cmd_valid && i_cmd_ready) o_cmd_valid <= 1'b0;
                    if (i_result_valid) begin
                        if (i_result_nack) begin
                            nack_q <= 1'b1;   // idx keeps the failing entry
                            state  <= S_IDLE;
                        end else begin
                            state <= S_NEXT;
                        end
                    end
                end
                S_NEXT: begin
                    if (({1'b0, idx} + 4'd1) >= i_count) begin
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        idx   <= idx + 3'd1;
                        state <= S_READ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_ISSUE) begin
            o_cmd <= '{dev_addr: `CODEC_I2C_ADDR, word: i_word};
        end
    end

    // Master reports only for the one command in flight
    a_result_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_result_valid |-> (state == S_WAIT));

endmodule

`default_nettype wire

// File: hw/codec_cfg_apb.sv
`timescale 1ns/1ps
`default_nettype none

`include "codec_cfg_consts.svh"

module codec_cfg_apb import codec_cfg_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  apb_req_t    i_apb,
    input  cfg_status_t i_status,
    input  codec_word_t i_host_word,
    output apb_rsp_t    o_apb,
    output logic        o_start,
    output logic [3:0]  o_count,
    output logic        o_wr_en,
    output logic [2:0]  o_wr_idx,
    output codec_word_t o_wr_word,
    output logic [2:0]  o_host_idx
);

    localparam logic [7:0] TBL_END = 8'(`CFG_REG_TABLE + 4 * `CFG_TABLE_DEPTH);

    logic       access;
    logic       sel_ctrl;
    logic       sel_status;
    logic       sel_count;
    logic       sel_table;
    logic       mapped;
    logic       busy;
    logic       wr_blocked;
    logic       wr_ok;
    logic       rd_wait;
    logic [7:0] tbl_off;

    function automatic logic [3:0] clip_count(input logic [31:0] v);
        if (v == 32'd0) return 4'd1;
        if (v > 32'(`CFG_TABLE_DEPTH)) return 4'(`CFG_TABLE_DEPTH);
        return v[3:0];
    endfunction

    assign access     = i_apb.psel && i_apb.penable;
    assign sel_ctrl   = (i_apb.paddr == `CFG_REG_CTRL);
    assign sel_status = (i_apb.paddr == `CFG_REG_STATUS);
    assign sel_count  = (i_apb.paddr == `CFG_REG_COUNT);
    assign sel_table  = (i_apb.paddr >= `CFG_REG_TABLE) && (i_apb.paddr < TBL_END) &&
                        (i_apb.paddr[1:0] == 2'b00);
    assign mapped     = sel_ctrl || sel_status || sel_count || sel_table;
    assign tbl_off    = i_apb.paddr - `CFG_REG_TABLE;

    // Pending start counts as busy until the sequencer picks it up
    assign busy       = i_status.busy || o_start;
    assign wr_blocked = i_apb.pwrite && busy && (sel_table || sel_count);

    always_comb begin
        o_apb.pready  = access && !(sel_table && !i_apb.pwrite && !rd_wait);
        o_apb.pslverr = o_apb.pready && (!mapped || wr_blocked);
        o_apb.prdata  = 32'd0;   // Control and unmapped read zero
        if (sel_status) o_apb.prdata = {24'd0, i_status};
        if (sel_count)  o_apb.prdata = {28'd0, o_count};
        if (sel_table)  o_apb.prdata = {16'd0, i_host_word};
    end

    assign wr_ok      = o_apb.pready && i_apb.pwrite && mapped && !wr_blocked;
    assign o_wr_en    = wr_ok && sel_table;
    assign o_wr_idx   = tbl_off[4:2];
    assign o_wr_word  = codec_word_t'(i_apb.pwdata[15:0]);
    assign o_host_idx = tbl_off[4:2];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_wait <= 1'b0;
            o_start <= 1'b0;
            o_count <= 4'(`CFG_DEFAULT_COUNT);
        end else begin
            rd_wait <= access && sel_table && !i_apb.pwrite && !rd_wait;   // One wait state
            o_start <= wr_ok && sel_ctrl && i_apb.pwdata[0] && !busy;
            if (wr_ok && sel_count) o_count <= clip_count(i_apb.pwdata);
        end
    end

    a_penable_needs_psel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_apb.penable |-> i_apb.psel);

endmodule

`default_nettype wire

// File: hw/codec_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "codec_cfg_consts.svh"

module codec_cfg_top import codec_cfg_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    input  logic     i_sda,
    output logic     o_scl_oe,
    output logic     o_sda_oe
);

    cfg_status_t status;
    codec_word_t host_word;
    codec_word_t seq_word;
    codec_word_t wr_word;
    i2c_cmd_t    cmd;
    logic        start;
    logic [3:0]  count;
    logic        wr_en;
    logic [2:0]  wr_idx;
    logic [2:0]  host_idx;
    logic [2:0]  seq_idx;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        result_valid;
    logic        result_nack;

    codec_cfg_apb u_apb (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb),
        .i_status    (status),
        .i_host_word (host_word),
        .o_apb       (o_apb),
        .o_start     (start),
        .o_count     (count),
        .o_wr_en     (wr_en),
        .o_wr_idx    (wr_idx),
        .o_wr_word   (wr_word),
        .o_host_idx  (host_idx)
    );

    codec_init_table u_table (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_en     (wr_en),
        .i_wr_idx    (wr_idx),
        .i_wr_word   (wr_word),
        .i_host_idx  (host_idx),
        .i_seq_idx   (seq_idx),
        .o_host_word (host_word),
        .o_seq_word  (seq_word)
    );

    codec_init_sequencer u_seq (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (start),
        .i_count        (count),
        .i_word         (seq_word),
        .i_cmd_ready    (cmd_ready),
        .i_result_valid (result_valid),
        .i_result_nack  (result_nack),
        .o_rd_idx       (seq_idx),
        .o_cmd_valid    (cmd_valid),
        .o_cmd          (cmd),
        .o_status       (status)
    );

    i2c_write_master #(
        .QUARTER_DIV (`I2C_QUARTER_DIV)
    ) u_master (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cmd_valid    (cmd_valid),
        .i_cmd          (cmd),
        .i_sda          (i_sda),
        .o_cmd_ready    (cmd_ready),
        .o_result_valid (result_valid),
        .o_result_nack  (result_nack),
        .o_scl_oe       (o_scl_oe),
        .o_sda_oe       (o_sda_oe)
    );

endmodule

`default_nettype wire

// File: sim/i2c_codec_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_codec_model #(
    parameter logic [6:0] DEV_ADDR = 7'h1A
) (
    input  logic i_clk,
    input  logic i_scl,
    input  logic i_sda,
    input  logic i_refuse,   // Refuse the address byte
    output logic o_sda_oe
);

    localparam logic [7:0] DEV_BYTE     = {DEV_ADDR, 1'b0};   // Write direction
    localparam int         MAX_CAPTURES = 64;

    // Completed three-byte writes, oldest first
    logic [23:0] captures [MAX_CAPTURES];
    int          capture_count;

    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic [3:0]  bit_cnt;    // 8 is the ack slot, 9 releases it
    logic [1:0]  byte_cnt;
    logic [7:0]  shreg;
    logic [23:0] frame;

    initial begin
        capture_count = 0;
        scl_q         = 1'b1;
        sda_q         = 1'b1;
        active        = 1'b0;
        bit_cnt       = 4'd0;
        byte_cnt      = 2'd0;
        shreg         = 8'd0;
        frame         = 24'd0;
        o_sda_oe      = 1'b0;
    end

    // Bus oversampled with the system clock, edges found against last sample
    always @(posedge i_clk) begin
        scl_q <= i_scl;
        sda_q <= i_sda;
        if (scl_q && i_scl && sda_q && !i_sda) begin
            active   <= 1'b1;   // Start
            bit_cnt  <= 4'd0;
            byte_cnt <= 2'd0;
        end else if (scl_q && i_scl && !sda_q && i_sda) begin
            // Stop closes the write
            if (active && byte_cnt == 2'd3 && capture_count < MAX_CAPTURES) begin
                captures[capture_count] <= frame;
                capture_count           <= capture_count + 1;
            end
            active   <= 1'b0;
            o_sda_oe <= 1'b0;
        end else if (active && !scl_q && i_scl) begin
            if (bit_cnt == 4'd8) begin
                frame    <= {frame[15:0], shreg};   // Byte acknowledged
                byte_cnt <= byte_cnt + 2'd1;
                bit_cnt  <= 4'd9;
            end else if (bit_cnt < 4'd8) begin
                shreg   <= {shreg[6:0], i_sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else if (active && scl_q && !i_scl) begin
            if (bit_cnt == 4'd8) begin
                if (byte_cnt != 2'd0 || (shreg == DEV_BYTE && !i_refuse)) begin
                    o_sda_oe <= 1'b1;   // Ack by pulling SDA low
                end else begin
                    active <= 1'b0;     // Not for us, stay off the bus
                end
            end else if (bit_cnt == 4'd9) begin
                o_sda_oe <= 1'b0;
                bit_cnt  <= 4'd0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_codec_cfg.sv
`timescale 1ns/1ps
`default_nettype none

`include "codec_cfg_consts.svh"

module tb_codec_cfg import codec_cfg_pkg::*; ();

    localparam int         HALF_PERIOD = 4;
    localparam int         SAMPLE_DLY  = 2;      // Inside the low phase of the clock
    localparam int         APB_TIMEOUT = 16;     // Cycles for pready
    localparam int         POLL_LIMIT  = 4000;   // Status reads before giving up
    localparam logic [7:0] DEV_BYTE    = 8'h34;  // Codec address byte, write direction

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     dut_scl_oe;
    logic     dut_sda_oe;
    logic     model_sda_oe;
    logic     refuse;
    logic     scl;
    logic     sda;

    int checks;
    int mismatches;
    int failures;
    int cap_ptr;   // Next model capture to compare

    // Open-drain lines with pull-ups, the model never holds SCL
    assign scl = ~dut_scl_oe;
    assign sda = ~(dut_sda_oe | model_sda_oe);

    codec_cfg_top i_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_apb    (apb_req),
        .o_apb    (apb_rsp),
        .i_sda    (sda),
        .o_scl_oe (dut_scl_oe),
        .o_sda_oe (dut_sda_oe)
    );

    i2c_codec_model #(
        .DEV_ADDR (`CODEC_I2C_ADDR)
    ) u_model (
        .i_clk    (clk),
        .i_scl    (scl),
        .i_sda    (sda),
        .i_refuse (refuse),
        .o_sda_oe (model_sda_oe)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Setup and access phases launched on falling edges
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waits = 0;
        #(SAMPLE_DLY);
        while (!apb_rsp.pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            #(SAMPLE_DLY);
            waits++;
        end
        if (!apb_rsp.pready) begin
            failures++;
            $display("APB transfer to address %h got no pready in %0d cycles", addr, waits);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic start_and_wait();
        logic [31:0] rdata;
        logic        err;
        cfg_status_t status;
        int          polls;
        // Every earlier write on the bus must have been expected
        check_value("captures_before_start", u_model.capture_count, cap_ptr);
        apb_transfer(1'b1, `CFG_REG_CTRL, 32'd1, rdata, err);
        check_value("start_pslverr", {31'd0, err}, 32'd0);
        polls  = 0;
        status = '{busy: 1'b1, default: '0};
        while (status.busy !== 1'b0 && polls < POLL_LIMIT) begin
            apb_transfer(1'b0, `CFG_REG_STATUS, 32'd0, rdata, err);
            status = cfg_status_t'(rdata[7:0]);
            polls++;
        end
        if (status.busy !== 1'b0) begin
            failures++;
            $display("Sequence still busy after %0d status reads", polls);
        end
    endtask

    task automatic check_capture(input logic [15:0] word);
        logic [23:0] cap;
        if (cap_ptr >= u_model.capture_count) begin
            failures++;
            $display("Expected control word %h but the codec model recorded no more writes",
                     word);
        end else begin
            cap = u_model.captures[cap_ptr];
            cap_ptr++;
            check_value("capture_dev_byte", {24'd0, cap[23:16]}, {24'd0, DEV_BYTE});
            check_value("capture_word", {16'd0, cap[15:0]}, {16'd0, word});
        end
    endtask

    task automatic run_vectors();
        int               fd;
        int               code;
        logic [7:0]       op;
        logic [31:0]      f_addr;
        logic [31:0]      f_data;
        logic [31:0]      f_exp;
        logic [31:0]      rdata;
        logic             err;
        logic [8*160-1:0] skip;
        fd = $fopen("sim/codec_cfg_vectors.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the vector file sim/codec_cfg_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            case (op)
                "#": code = $fgets(skip, fd);
                "W", "R": begin
                    code = $fscanf(fd, " %h %h %h", f_addr, f_data, f_exp);
                    if (code != 3) begin
                        failures++;
                        $display("Vector line for %c has missing fields", op);
                    end else begin
                        apb_transfer(op == "W", f_addr[7:0], f_data, rdata, err);
                        if (op == "R") check_value("prdata", rdata, f_data);
                        check_value("pslverr", {31'd0, err}, {31'd0, f_exp[0]});
                    end
                end
                "G": start_and_wait();
                "E": begin
                    code = $fscanf(fd, " %h", f_data);
                    if (code == 1) begin
                        check_capture(f_data[15:0]);
                    end else begin
                        failures++;
                        $display("Vector line for %c has a missing field", op);
                    end
                end
                "N": begin
                    code = $fscanf(fd, " %h", f_data);
                    if (code == 1) begin
                        @(negedge clk);
                        refuse = f_data[0];
                    end else begin
                        failures++;
                        $display("Vector line for %c has a missing field", op);
                    end
                end
                default: begin
                    failures++;
                    $display("Unknown vector operation %c", op);
                    code = $fgets(skip, fd);
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        apb_req    = '0;
        refuse     = 1'b0;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        cap_ptr    = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // Bus released after reset
        check_value("scl_oe_after_reset", {31'd0, dut_scl_oe}, 32'd0);
        check_value("sda_oe_after_reset", {31'd0, dut_sda_oe}, 32'd0);
        run_vectors();
        check_value("unexpected_captures", u_model.capture_count, cap_ptr);
        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/codec_cfg_vectors.txt
# W addr data pslverr | R addr expected pslverr | G | E word | N refuse (all hex)
# E words are the 16-bit control words the codec model records, in bus order
R 04 00000000 0
R 08 00000007 0
R 40 00001E00 0
R 44 00000815 0
R 48 00000A00 0
R 4C 00000C00 0
R 50 00000E42 0
R 54 00001019 0
R 58 00001201 0
G
E 1E00
E 0815
E 0A00
E 0C00
E 0E42
E 1019
E 1201
R 04 00000032 0
W 40 00000C1F 0
W 44 00000A06 0
W 48 00001003 0
W 08 00000003 0
R 44 00000A06 0
G
E 0C1F
E 0A06
E 1003
R 04 00000012 0
W 08 00000000 0
R 08 00000001 0
W 08 0000000C 0
R 08 00000008 0
W 08 00000003 0
N 1
G
R 04 00000004 0
N 0
W 00 00000001 0
W 44 00001234 1
W 08 00000005 1
W 00 00000001 0
G
E 0C1F
E 0A06
E 1003
R 44 00000A06 0
R 08 00000003 0
R 04 00000012 0
W 20 0000FFFF 1
R 20 00000000 1

// File: all.f
+incdir+hw
hw/codec_cfg_pkg.sv
hw/codec_init_table.sv
hw/i2c_write_master.sv
hw/codec_init_sequencer.sv
hw/codec_cfg_apb.sv
hw/codec_cfg_top.sv
sim/i2c_codec_model.sv
sim/tb_codec_cfg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_codec_cfg
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f all.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
